//--- verilog/router_pkg.sv
// router_pkg: direction codes, flit layout, fifo sizing and direction helper functions
package router_pkg;

//==============================
// direction codes
//==============================
localparam int DIR_W = 2;
localparam logic [DIR_W-1:0] NORTH = 2'd0; // y - 1
localparam logic [DIR_W-1:0] EAST  = 2'd1; // x + 1
localparam logic [DIR_W-1:0] SOUTH = 2'd2; // y + 1
localparam logic [DIR_W-1:0] WEST  = 2'd3; // x - 1

//==============================
// tile id and flit layout
//==============================
localparam int TILE_ID_W = 4;             // {y, x}
localparam int COORD_W   = TILE_ID_W / 2; // 2-bit coords, wrap at mesh edge

localparam int ADDR_W   = 16;
localparam int DATA_W   = 16;
localparam int OPCODE_W = 2;
localparam int REQ_ID_W = 4;

// fields packed from the lsb up
localparam int DATA_LSB     = 0;
localparam int ADDR_LSB     = DATA_LSB + DATA_W;
localparam int OPCODE_LSB   = ADDR_LSB + ADDR_W;
localparam int REQ_ID_LSB   = OPCODE_LSB + OPCODE_W;
localparam int NEXT_ARB_LSB = REQ_ID_LSB + REQ_ID_W; // arbiter code at the next tile
localparam int TRANS_W      = NEXT_ARB_LSB + DIR_W;  // 40 bits

// destination tile sits in the address msbs
localparam int DEST_LSB = ADDR_LSB + ADDR_W - TILE_ID_W;

//==============================
// buffering and ready vectors
//==============================
localparam int FIFO_DEPTH = 4; // power of two, pointers wrap naturally
localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
localparam int FIFO_CNT_W = $clog2(FIFO_DEPTH + 1);

localparam int READY_W = 3;       // one bit per arbiter code except the link's own
localparam int NUM_SRC = READY_W; // input links feeding each arbiter
localparam int SRC_W   = $clog2(NUM_SRC);

// swaps north with south and east with west
function automatic logic [DIR_W-1:0] opposite_dir(input logic [DIR_W-1:0] dir);
    return dir ^ 2'b10;
endfunction

// bit position of an arbiter code in a ready vector that skips own
function automatic logic [DIR_W-1:0] skip_pos(input logic [DIR_W-1:0] own,
                                              input logic [DIR_W-1:0] code);
    return (code > own) ? code - 1'b1 : code;
endfunction

endpackage

//--- verilog/lookahead_route.sv
// lookahead_route: xy choice of the arbiter code a flit uses at the tile beyond OUT_DIR
`timescale 1ns/1ps
module lookahead_route
import router_pkg::*;
#(
    parameter logic [DIR_W-1:0] OUT_DIR = NORTH
)(
    input  logic [TILE_ID_W-1:0] local_tile_id,
    input  logic [TRANS_W-1:0]   flit_in,
    output logic [TRANS_W-1:0]   flit_out  // same flit, next-arb field replaced
);

logic [COORD_W-1:0] local_x;
logic [COORD_W-1:0] local_y;
logic [COORD_W-1:0] nb_x;    // neighbor tile one hop out
logic [COORD_W-1:0] nb_y;
logic [COORD_W-1:0] dest_x;
logic [COORD_W-1:0] dest_y;
logic [DIR_W-1:0]   next_arb;

assign local_x = local_tile_id[COORD_W-1:0];
assign local_y = local_tile_id[TILE_ID_W-1:COORD_W];
assign dest_x  = flit_in[DEST_LSB +: COORD_W];
assign dest_y  = flit_in[DEST_LSB+COORD_W +: COORD_W];

// one hop in OUT_DIR, no edge check
always_comb begin
    nb_x = local_x;
    nb_y = local_y;
    case (OUT_DIR)
        NORTH:   nb_y = local_y - 1'b1;
        SOUTH:   nb_y = local_y + 1'b1;
        EAST:    nb_x = local_x + 1'b1;
        default: nb_x = local_x - 1'b1; // west
    endcase
end

// x first, then y, else eject at the neighbor
always_comb begin
    if (dest_x > nb_x)      next_arb = EAST;
    else if (dest_x < nb_x) next_arb = WEST;
    else if (dest_y > nb_y) next_arb = SOUTH;
    else if (dest_y < nb_y) next_arb = NORTH;
    else                    next_arb = opposite_dir(OUT_DIR); // arrival link code
end

always_comb begin
    flit_out = flit_in;
    flit_out[NEXT_ARB_LSB +: DIR_W] = next_arb;
end

endmodule

//--- verilog/tile_fifo.sv
// tile_fifo: circular flit buffer with a two-free-slots ready level
`timescale 1ns/1ps
module tile_fifo
import router_pkg::*;
(
    input  logic               clk,
    input  logic               arst_n,
    input  logic               push,
    input  logic [TRANS_W-1:0] push_flit,
    input  logic               pop,
    output logic               head_valid,
    output logic [TRANS_W-1:0] head_flit,
    output logic               ready       // room for two more flits
);

logic [TRANS_W-1:0]    mem [FIFO_DEPTH];
logic [FIFO_PTR_W-1:0] wr_ptr;
logic [FIFO_PTR_W-1:0] rd_ptr;
logic [FIFO_CNT_W-1:0] count;
logic                  do_push;
logic                  do_pop;

assign head_valid = (count != '0);
assign head_flit  = mem[rd_ptr];
assign ready      = (count <= FIFO_CNT_W'(FIFO_DEPTH - 2)); // winner stage makes ready stale
assign do_push    = push && (count != FIFO_CNT_W'(FIFO_DEPTH)); // drop when full
assign do_pop     = pop && head_valid;

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
    end else begin
        if (do_push) wr_ptr <= wr_ptr + 1'b1;
        if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
        case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count; // idle or push with pop
        endcase
    end
end

// storage
always_ff @(posedge clk) begin
    if (do_push)
        mem[wr_ptr] <= push_flit;
end

endmodule

//--- verilog/fifo_arb.sv
// fifo_arb: one output direction with per-source rewrite, fifos, round-robin and winner register
`timescale 1ns/1ps
module fifo_arb
import router_pkg::*;
#(
    parameter logic [DIR_W-1:0] OUT_DIR = NORTH
)(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [TILE_ID_W-1:0] local_tile_id,
    //==============================
    // flits from the other links
    //==============================
    input  logic                 alloc_valid0,
    input  logic                 alloc_valid1,
    input  logic                 alloc_valid2,
    input  logic [TRANS_W-1:0]   alloc_flit0,
    input  logic [TRANS_W-1:0]   alloc_flit1,
    input  logic [TRANS_W-1:0]   alloc_flit2,
    output logic                 fifo_ready0,
    output logic                 fifo_ready1,
    output logic                 fifo_ready2,
    //==============================
    // toward the neighbor tile
    //==============================
    output logic                 winner_valid, // one-cycle pulse per flit
    output logic [TRANS_W-1:0]   winner_flit,
    input  logic [READY_W-1:0]   down_ready    // neighbor arbiters, skips our arrival code
);

logic [DIR_W-1:0]   eject_arb;  // code of the link we land on at the neighbor
logic [NUM_SRC-1:0] alloc_valid;
logic [TRANS_W-1:0] alloc_flit [NUM_SRC];
logic [TRANS_W-1:0] route_flit [NUM_SRC];
logic [NUM_SRC-1:0] fifo_ready;
logic [NUM_SRC-1:0] head_valid;
logic [TRANS_W-1:0] head_flit [NUM_SRC];
logic [NUM_SRC-1:0] eligible;
logic [NUM_SRC-1:0] pop;
logic [SRC_W-1:0]   rr_ptr;     // highest priority source
logic [SRC_W-1:0]   grant_idx;
logic               grant_any;

assign eject_arb   = opposite_dir(OUT_DIR);
assign alloc_valid = {alloc_valid2, alloc_valid1, alloc_valid0};
assign alloc_flit[0] = alloc_flit0;
assign alloc_flit[1] = alloc_flit1;
assign alloc_flit[2] = alloc_flit2;
assign fifo_ready0 = fifo_ready[0];
assign fifo_ready1 = fifo_ready[1];
assign fifo_ready2 = fifo_ready[2];

// rewrite on the way in, then buffer per source
for (genvar i = 0; i < NUM_SRC; i++) begin : g_src
    lookahead_route #(.OUT_DIR(OUT_DIR)) u_route (
        .local_tile_id (local_tile_id),
        .flit_in       (alloc_flit[i]),
        .flit_out      (route_flit[i])
    );
    tile_fifo u_fifo (
        .clk        (clk),
        .arst_n     (arst_n),
        .push       (alloc_valid[i]),
        .push_flit  (route_flit[i]),
        .pop        (pop[i]),
        .head_valid (head_valid[i]),
        .head_flit  (head_flit[i]),
        .ready      (fifo_ready[i])
    );
end

// head may go when its neighbor arbiter has room, ejection always may
always_comb begin
    logic [DIR_W-1:0] code;
    for (int i = 0; i < NUM_SRC; i++) begin
        code = head_flit[i][NEXT_ARB_LSB +: DIR_W];
        eligible[i] = head_valid[i] &&
                      ((code == eject_arb) || down_ready[skip_pos(eject_arb, code)]);
    end
end

//==============================
// round-robin pick
//==============================
always_comb begin
    int idx;
    grant_any = 1'b0;
    grant_idx = '0;
    pop       = '0;
    for (int off = 0; off < NUM_SRC; off++) begin
        idx = int'(rr_ptr) + off;
        if (idx >= NUM_SRC)
            idx = idx - NUM_SRC; // wrap source index
        if (!grant_any && eligible[idx]) begin
            grant_any = 1'b1;
            grant_idx = SRC_W'(idx);
        end
    end
    if (grant_any)
        pop[grant_idx] = 1'b1; // winner leaves its fifo
end

always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
        winner_valid <= 1'b0;
        rr_ptr       <= '0;
    end else begin
        winner_valid <= grant_any;
        if (grant_any) // next source after the winner
            rr_ptr <= (grant_idx == SRC_W'(NUM_SRC - 1)) ? '0 : grant_idx + 1'b1;
    end
end

// winner payload
always_ff @(posedge clk) begin
    if (grant_any)
        winner_flit <= head_flit[grant_idx];
end

endmodule

//--- verilog/router.sv
// router: four-link mesh tile router, next-arb decode into four output arbiters
`timescale 1ns/1ps
module router
import router_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic [TILE_ID_W-1:0] local_tile_id,
    //==============================
    // north link
    //==============================
    input  logic                 in_north_valid,
    input  logic [TRANS_W-1:0]   in_north_flit,
    output logic [READY_W-1:0]   out_north_ready, // east, south, west arb
    output logic                 out_north_valid,
    output logic [TRANS_W-1:0]   out_north_flit,
    input  logic [READY_W-1:0]   in_north_ready,  // neighbor: north, east, west arb
    //==============================
    // east link
    //==============================
    input  logic                 in_east_valid,
    input  logic [TRANS_W-1:0]   in_east_flit,
    output logic [READY_W-1:0]   out_east_ready,  // north, south, west arb
    output logic                 out_east_valid,
    output logic [TRANS_W-1:0]   out_east_flit,
    input  logic [READY_W-1:0]   in_east_ready,   // neighbor: north, east, south arb
    //==============================
    // south link
    //==============================
    input  logic                 in_south_valid,
    input  logic [TRANS_W-1:0]   in_south_flit,
    output logic [READY_W-1:0]   out_south_ready, // north, east, west arb
    output logic                 out_south_valid,
    output logic [TRANS_W-1:0]   out_south_flit,
    input  logic [READY_W-1:0]   in_south_ready,  // neighbor: east, south, west arb
    //==============================
    // west link
    //==============================
    input  logic                 in_west_valid,
    input  logic [TRANS_W-1:0]   in_west_flit,
    output logic [READY_W-1:0]   out_west_ready,  // north, east, south arb
    output logic                 out_west_valid,
    output logic [TRANS_W-1:0]   out_west_flit,
    input  logic [READY_W-1:0]   in_west_ready    // neighbor: north, south, west arb
);

// a code naming the arrival link matches nothing, local core port not built
logic in_north_match_east;
logic in_north_match_south;
logic in_north_match_west;
logic in_east_match_north;
logic in_east_match_south;
logic in_east_match_west;
logic in_south_match_north;
logic in_south_match_east;
logic in_south_match_west;
logic in_west_match_north;
logic in_west_match_east;
logic in_west_match_south;

assign in_north_match_east  = in_north_valid && (in_north_flit[NEXT_ARB_LSB +: DIR_W] == EAST);
assign in_north_match_south = in_north_valid && (in_north_flit[NEXT_ARB_LSB +: DIR_W] == SOUTH);
assign in_north_match_west  = in_north_valid && (in_north_flit[NEXT_ARB_LSB +: DIR_W] == WEST);
assign in_east_match_north  = in_east_valid  && (in_east_flit[NEXT_ARB_LSB +: DIR_W]  == NORTH);
assign in_east_match_south  = in_east_valid  && (in_east_flit[NEXT_ARB_LSB +: DIR_W]  == SOUTH);
assign in_east_match_west   = in_east_valid  && (in_east_flit[NEXT_ARB_LSB +: DIR_W]  == WEST);
assign in_south_match_north = in_south_valid && (in_south_flit[NEXT_ARB_LSB +: DIR_W] == NORTH);
assign in_south_match_east  = in_south_valid && (in_south_flit[NEXT_ARB_LSB +: DIR_W] == EAST);
assign in_south_match_west  = in_south_valid && (in_south_flit[NEXT_ARB_LSB +: DIR_W] == WEST);
assign in_west_match_north  = in_west_valid  && (in_west_flit[NEXT_ARB_LSB +: DIR_W]  == NORTH);
assign in_west_match_east   = in_west_valid  && (in_west_flit[NEXT_ARB_LSB +: DIR_W]  == EAST);
assign in_west_match_south  = in_west_valid  && (in_west_flit[NEXT_ARB_LSB +: DIR_W]  == SOUTH);

//==============================
// north arbiter, src east/south/west
//==============================
fifo_arb #(.OUT_DIR(NORTH)) fifo_arb_north (
    .clk           (clk),
    .arst_n        (arst_n),
    .local_tile_id (local_tile_id),
    .alloc_valid0  (in_east_match_north),
    .alloc_valid1  (in_south_match_north),
    .alloc_valid2  (in_west_match_north),
    .alloc_flit0   (in_east_flit),
    .alloc_flit1   (in_south_flit),
    .alloc_flit2   (in_west_flit),
    .fifo_ready0   (out_east_ready[0]),  // north is bit 0 on every other link
    .fifo_ready1   (out_south_ready[0]),
    .fifo_ready2   (out_west_ready[0]),
    .winner_valid  (out_north_valid),
    .winner_flit   (out_north_flit),
    .down_ready    (in_north_ready)
);

//==============================
// east arbiter, src north/south/west
//==============================
fifo_arb #(.OUT_DIR(EAST)) fifo_arb_east (
    .clk           (clk),
    .arst_n        (arst_n),
    .local_tile_id (local_tile_id),
    .alloc_valid0  (in_north_match_east),
    .alloc_valid1  (in_south_match_east),
    .alloc_valid2  (in_west_match_east),
    .alloc_flit0   (in_north_flit),
    .alloc_flit1   (in_south_flit),
    .alloc_flit2   (in_west_flit),
    .fifo_ready0   (out_north_ready[0]),
    .fifo_ready1   (out_south_ready[1]),
    .fifo_ready2   (out_west_ready[1]),
    .winner_valid  (out_east_valid),
    .winner_flit   (out_east_flit),
    .down_ready    (in_east_ready)
);

//==============================
// south arbiter, src north/east/west
//==============================
fifo_arb #(.OUT_DIR(SOUTH)) fifo_arb_south (
    .clk           (clk),
    .arst_n        (arst_n),
    .local_tile_id (local_tile_id),
    .alloc_valid0  (in_north_match_south),
    .alloc_valid1  (in_east_match_south),
    .alloc_valid2  (in_west_match_south),
    .alloc_flit0   (in_north_flit),
    .alloc_flit1   (in_east_flit),
    .alloc_flit2   (in_west_flit),
    .fifo_ready0   (out_north_ready[1]),
    .fifo_ready1   (out_east_ready[1]),
    .fifo_ready2   (out_west_ready[2]),
    .winner_valid  (out_south_valid),
    .winner_flit   (out_south_flit),
    .down_ready    (in_south_ready)
);

//==============================
// west arbiter, src north/east/south
//==============================
fifo_arb #(.OUT_DIR(WEST)) fifo_arb_west (
    .clk           (clk),
    .arst_n        (arst_n),
    .local_tile_id (local_tile_id),
    .alloc_valid0  (in_north_match_west),
    .alloc_valid1  (in_east_match_west),
    .alloc_valid2  (in_south_match_west),
    .alloc_flit0   (in_north_flit),
    .alloc_flit1   (in_east_flit),
    .alloc_flit2   (in_south_flit),
    .fifo_ready0   (out_north_ready[2]), // west is always the top bit
    .fifo_ready1   (out_east_ready[2]),
    .fifo_ready2   (out_south_ready[2]),
    .winner_valid  (out_west_valid),
    .winner_flit   (out_west_flit),
    .down_ready    (in_west_ready)
);

endmodule

//--- verification/router_tb.sv
// router_tb: table, contention, back-pressure and lfsr random traffic test of the mesh router
`timescale 1ns/1ps
module router_tb
import router_pkg::*;
();

localparam int N_ROWS      = 8;
localparam int N_RAND      = 200;
localparam int WATCHDOG_NS = (N_ROWS + N_RAND) * 20 * 10;

logic                 clk;
logic                 arst_n;
logic [TILE_ID_W-1:0] tile_id;
logic [3:0]           in_valid;            // indexed by direction code
logic [TRANS_W-1:0]   in_flit [4];
logic [READY_W-1:0]   down_rdy [4];        // neighbor readiness, into in_x_ready
logic [READY_W-1:0]   up_rdy [4];          // from out_x_ready
logic [3:0]           out_valid;
logic [TRANS_W-1:0]   out_flit [4];
logic [16:0]          lfsr_state;
int                   rr_model [4];        // modeled round-robin pointer per output
logic [TRANS_W-1:0]   sb_q [4][$];         // owed flits per output
logic                 rand_on;

// table columns
logic [TILE_ID_W-1:0] row_tile [N_ROWS];
logic [DIR_W-1:0]     row_src [N_ROWS];
logic [DIR_W-1:0]     row_code [N_ROWS];
logic [TILE_ID_W-1:0] row_dest [N_ROWS];
logic [READY_W-1:0]   row_rdy [N_ROWS];
logic                 row_exp_valid [N_ROWS];
logic [DIR_W-1:0]     row_exp_dir [N_ROWS];
logic [DIR_W-1:0]     row_exp_code [N_ROWS];

router uut (
    .clk (clk), .arst_n (arst_n), .local_tile_id (tile_id),
    .in_north_valid (in_valid[0]), .in_north_flit (in_flit[0]), .out_north_ready (up_rdy[0]),
    .out_north_valid (out_valid[0]), .out_north_flit (out_flit[0]), .in_north_ready (down_rdy[0]),
    .in_east_valid (in_valid[1]), .in_east_flit (in_flit[1]), .out_east_ready (up_rdy[1]),
    .out_east_valid (out_valid[1]), .out_east_flit (out_flit[1]), .in_east_ready (down_rdy[1]),
    .in_south_valid (in_valid[2]), .in_south_flit (in_flit[2]), .out_south_ready (up_rdy[2]),
    .out_south_valid (out_valid[2]), .out_south_flit (out_flit[2]), .in_south_ready (down_rdy[2]),
    .in_west_valid (in_valid[3]), .in_west_flit (in_flit[3]), .out_west_ready (up_rdy[3]),
    .out_west_valid (out_valid[3]), .out_west_flit (out_flit[3]), .in_west_ready (down_rdy[3])
);

initial clk = 1'b0;
always #5 clk = ~clk; // 10 ns period

//==============================
// model helpers
//==============================
function automatic logic [16:0] lfsr_next(input logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]}; // x^17 + x^14 + 1
endfunction

function automatic logic [15:0] take_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state); // one step per bit
        v = {v[14:0], lfsr_state[0]};
    end
    return v;
endfunction

function automatic string dir_name(input int d);
    case (d)
        0: return "north";
        1: return "east";
        2: return "south";
        default: return "west";
    endcase
endfunction

function automatic string out_name(input int d, input string field);
    return {"out_", dir_name(d), "_", field};
endfunction

function automatic logic [DIR_W-1:0] rev_dir(input logic [DIR_W-1:0] d);
    return d + 2'd2;
endfunction

// ready vector bit for a code, own code skipped
function automatic logic [DIR_W-1:0] bit_pos(input logic [DIR_W-1:0] own,
                                             input logic [DIR_W-1:0] code);
    return (code > own) ? code - 2'd1 : code;
endfunction

function automatic logic [TRANS_W-1:0] make_flit(input logic [TILE_ID_W-1:0] dest,
        input logic [DIR_W-1:0] code, input logic [REQ_ID_W-1:0] req,
        input logic [OPCODE_W-1:0] op, input logic [DATA_W-1:0] data);
    logic [TRANS_W-1:0] f;
    f = '0;
    f[DATA_LSB +: DATA_W]     = data;
    f[ADDR_LSB +: ADDR_W]     = {dest, data[11:0] ^ 12'h5a5}; // dest in addr msbs
    f[OPCODE_LSB +: OPCODE_W] = op;
    f[REQ_ID_LSB +: REQ_ID_W] = req;
    f[NEXT_ARB_LSB +: DIR_W]  = code;
    return f;
endfunction

// xy choice at the neighbor beyond out
function automatic logic [DIR_W-1:0] xy_code(input logic [TILE_ID_W-1:0] tile,
        input logic [DIR_W-1:0] out, input logic [TILE_ID_W-1:0] dest);
    logic [1:0] nx;
    logic [1:0] ny;
    nx = tile[1:0];
    ny = tile[3:2];
    if (out == NORTH) ny = ny - 2'd1;
    else if (out == SOUTH) ny = ny + 2'd1;
    else if (out == EAST) nx = nx + 2'd1;
    else nx = nx - 2'd1;
    if (dest[1:0] != nx) return (dest[1:0] > nx) ? EAST : WEST;
    if (dest[3:2] != ny) return (dest[3:2] > ny) ? SOUTH : NORTH;
    return rev_dir(out); // neighbor is the destination
endfunction

function automatic logic [TRANS_W-1:0] rewrite(input logic [TRANS_W-1:0] f,
        input logic [TILE_ID_W-1:0] tile, input logic [DIR_W-1:0] out);
    logic [TRANS_W-1:0] r;
    r = f;
    r[NEXT_ARB_LSB +: DIR_W] = xy_code(tile, out, f[ADDR_LSB+ADDR_W-TILE_ID_W +: TILE_ID_W]);
    return r;
endfunction

function automatic int owed();
    int n;
    n = 0;
    for (int o = 0; o < 4; o++)
        n = n + sb_q[o].size();
    return n;
endfunction

//==============================
// checks and stimulus tasks
//==============================
task automatic abort_run(input string why);
    if (why != "")
        $display("%s", why);
    $display("TEST RESULT: FAIL");
    $fatal(1, "router_tb stopped");
endtask

task automatic check_valid(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("Error at %0t ns: %s expected %0b actual %0b", $time, name, exp, act);
        abort_run("");
    end
endtask

task automatic check_flit(input string name, input logic [TRANS_W-1:0] exp,
                          input logic [TRANS_W-1:0] act);
    if (act !== exp) begin
        $display("Error at %0t ns: %s expected %h actual %h", $time, name, exp, act);
        abort_run("");
    end
endtask

task automatic check_ready(input string name, input logic [READY_W-1:0] exp,
                           input logic [READY_W-1:0] act);
    if (act !== exp) begin
        $display("Error at %0t ns: %s expected %b actual %b", $time, name, exp, act);
        abort_run("");
    end
endtask

task automatic tick();
    @(posedge clk);
    #1; // drive just after the edge
endtask

task automatic idle_inputs();
    in_valid = '0;
    for (int d = 0; d < 4; d++)
        in_flit[d] = '0;
endtask

task automatic set_row(input int i, input logic [3:0] tile, input logic [1:0] src,
        input logic [1:0] code, input logic [3:0] dest, input logic [2:0] rdy,
        input logic ev, input logic [1:0] edir, input logic [1:0] ecode);
    row_tile[i]      = tile;
    row_src[i]       = src;
    row_code[i]      = code;
    row_dest[i]      = dest;
    row_rdy[i]       = rdy;
    row_exp_valid[i] = ev;
    row_exp_dir[i]   = edir;
    row_exp_code[i]  = ecode;
endtask

task automatic load_table();
    //      tile  src    code   dest  rdy     valid out    rewritten
    set_row(0, 4'd5, SOUTH, NORTH, 4'd3,  3'b111, 1'b1, NORTH, EAST);
    set_row(1, 4'd5, WEST,  EAST,  4'd14, 3'b111, 1'b1, EAST,  SOUTH);
    set_row(2, 4'd5, NORTH, SOUTH, 4'd8,  3'b111, 1'b1, SOUTH, WEST);
    set_row(3, 4'd5, EAST,  WEST,  4'd0,  3'b111, 1'b1, WEST,  NORTH);
    set_row(4, 4'd5, SOUTH, NORTH, 4'd1,  3'b000, 1'b1, NORTH, SOUTH); // eject, not ready
    set_row(5, 4'd5, NORTH, EAST,  4'd6,  3'b000, 1'b1, EAST,  WEST);
    set_row(6, 4'd5, NORTH, NORTH, 4'd3,  3'b111, 1'b0, NORTH, NORTH); // own link, dropped
    set_row(7, 4'd0, EAST,  WEST,  4'd3,  3'b000, 1'b1, WEST,  EAST);  // x wraps to 3
endtask

task automatic run_row(input int i);
    logic [TRANS_W-1:0] f;
    logic [TRANS_W-1:0] exp_f;
    logic               hit;
    int                 slot;
    f = make_flit(row_dest[i], row_code[i], 4'(i), 2'(i), 16'h1000 + 16'(i));
    exp_f = f;
    exp_f[NEXT_ARB_LSB +: DIR_W] = row_exp_code[i];
    tile_id = row_tile[i];
    for (int d = 0; d < 4; d++)
        down_rdy[d] = row_rdy[i];
    in_valid[row_src[i]] = 1'b1;
    in_flit[row_src[i]]  = f;
    tick();
    idle_inputs();
    tick(); // two edges after the sample edge
    for (int d = 0; d < 4; d++) begin
        hit = row_exp_valid[i] && (row_exp_dir[i] == DIR_W'(d));
        check_valid(out_name(d, "valid"), hit, out_valid[d]);
        if (hit)
            check_flit(out_name(d, "flit"), exp_f, out_flit[d]);
    end
    if (row_exp_valid[i]) begin
        slot = int'(bit_pos(row_exp_dir[i], row_src[i]));
        rr_model[row_exp_dir[i]] = (slot == 2) ? 0 : slot + 1;
    end
    tick();
    for (int d = 0; d < 4; d++)
        check_valid(out_name(d, "valid"), 1'b0, out_valid[d]); // single pulse
endtask

// north, south and west all aim east in one cycle
task automatic contention_test();
    logic [TRANS_W-1:0] f [4];
    int slot;
    int d;
    tile_id = 4'd5;
    for (int k = 0; k < 4; k++) begin
        down_rdy[k] = '1;
        f[k] = make_flit(4'd7, EAST, {DIR_W'(k), 2'b01}, 2'd2, 16'h2000 + 16'(k));
        if (k != int'(EAST)) begin
            in_valid[k] = 1'b1;
            in_flit[k]  = f[k];
        end
    end
    tick();
    idle_inputs();
    tick();
    slot = rr_model[EAST];
    for (int k = 0; k < 3; k++) begin
        d = (slot >= int'(EAST)) ? slot + 1 : slot; // source slot back to link
        check_valid("out_east_valid", 1'b1, out_valid[EAST]);
        check_flit("out_east_flit", rewrite(f[d], 4'd5, EAST), out_flit[EAST]);
        slot = (slot == 2) ? 0 : slot + 1;
        tick();
    end
    rr_model[EAST] = slot;
    check_valid("out_east_valid", 1'b0, out_valid[EAST]);
endtask

task automatic backpressure_test();
    logic [TRANS_W-1:0] f [3];
    tile_id = 4'd5;
    down_rdy[EAST][bit_pos(rev_dir(EAST), EAST)] = 1'b0; // hold code east beyond us
    for (int k = 0; k < 3; k++) begin
        check_ready("out_west_ready", 3'b111, up_rdy[WEST]);
        f[k] = make_flit(4'd7, EAST, {WEST, 2'(k)}, 2'd1, 16'h3000 + 16'(k));
        in_valid[WEST] = 1'b1;
        in_flit[WEST]  = f[k];
        tick();
    end
    idle_inputs();
    check_ready("out_west_ready", 3'b101, up_rdy[WEST]); // one free slot left
    repeat (4) begin
        check_valid("out_east_valid", 1'b0, out_valid[EAST]);
        tick();
    end
    down_rdy[EAST] = '1;
    tick();
    for (int k = 0; k < 3; k++) begin
        check_valid("out_east_valid", 1'b1, out_valid[EAST]);
        check_flit("out_east_flit", rewrite(f[k], 4'd5, EAST), out_flit[EAST]);
        tick();
    end
    check_valid("out_east_valid", 1'b0, out_valid[EAST]);
    check_ready("out_west_ready", 3'b111, up_rdy[WEST]);
    rr_model[EAST] = 0; // west is slot 2
endtask

task automatic random_test();
    int                 sent;
    int                 waited;
    logic [15:0]        r;
    logic [15:0]        s;
    logic [DIR_W-1:0]   code;
    logic [TRANS_W-1:0] f;
    sent = 0;
    rand_on = 1'b1;
    r = take_bits(4);
    tile_id = r[3:0];
    while (sent < N_RAND) begin
        for (int d = 0; d < 4; d++) begin
            in_valid[d] = 1'b0;
            r = take_bits(1);
            if (r[0] && sent < N_RAND) begin
                r = take_bits(2);
                code = r[1:0];
                // never our own link, and only while the target fifo has room
                if (code != DIR_W'(d) && up_rdy[d][bit_pos(DIR_W'(d), code)]) begin
                    r = take_bits(16);
                    s = take_bits(8);
                    f = make_flit(s[3:0], code, {DIR_W'(d), s[5:4]}, s[7:6], r);
                    in_valid[d] = 1'b1;
                    in_flit[d]  = f;
                    sb_q[code].push_back(rewrite(f, tile_id, code));
                    sent++;
                end
            end
        end
        for (int o = 0; o < 4; o++) begin
            r = take_bits(3);
            s = take_bits(3);
            down_rdy[o] = r[2:0] | s[2:0]; // mostly ready
        end
        tick();
    end
    idle_inputs();
    for (int o = 0; o < 4; o++)
        down_rdy[o] = '1;
    waited = 0;
    while (owed() != 0 && waited < 100) begin
        tick();
        waited++;
    end
    repeat (3) tick();
    rand_on = 1'b0;
endtask

//==============================
// scoreboard monitor, order kept per source link
//==============================
always @(negedge clk) begin : monitor
    int               hit;
    logic [DIR_W-1:0] src;
    if (rand_on) begin
        for (int o = 0; o < 4; o++) begin
            if (out_valid[o]) begin
                src = out_flit[o][REQ_ID_LSB+REQ_ID_W-DIR_W +: DIR_W]; // sender tag
                hit = -1;
                for (int k = 0; k < sb_q[o].size(); k++)
                    if (hit < 0 && sb_q[o][k][REQ_ID_LSB+REQ_ID_W-DIR_W +: DIR_W] == src)
                        hit = k;
                if (hit < 0) begin
                    abort_run({"a flit left on ", dir_name(o), " that was never sent there"});
                end else begin
                    check_flit(out_name(o, "flit"), sb_q[o][hit], out_flit[o]);
                    sb_q[o].delete(hit);
                end
            end
        end
    end
end

initial begin
    #(WATCHDOG_NS);
    abort_run("watchdog expired before the test finished");
end

initial begin
    lfsr_state = 17'd72971;
    rand_on    = 1'b0;
    tile_id    = 4'd5;
    arst_n     = 1'b0;
    idle_inputs();
    for (int d = 0; d < 4; d++) begin
        down_rdy[d] = '1;
        rr_model[d] = 0;
    end
    load_table();
    repeat (2) @(posedge clk);
    #1 arst_n = 1'b1;
    for (int d = 0; d < 4; d++) begin
        check_valid(out_name(d, "valid"), 1'b0, out_valid[d]);
        check_ready(out_name(d, "ready"), 3'b111, up_rdy[d]);
    end
    for (int i = 0; i < N_ROWS; i++)
        run_row(i);
    contention_test();
    backpressure_test();
    random_test();
    if (owed() != 0) begin
        abort_run("random traffic ended with flits that never left the router");
    end else begin
        $display("TEST RESULT: PASS");
        $finish;
    end
end

endmodule

//--- sim.f
verilog/router_pkg.sv
verilog/lookahead_route.sv
verilog/tile_fifo.sv
verilog/fifo_arb.sv
verilog/router.sv
verification/router_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the router testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module router_tb -f sim.f -o router_sim
sim_out=$(./obj_dir/router_sim 2>&1) || true
echo "$sim_out"
if grep -q "TEST RESULT: PASS" <<< "$sim_out"; then
    exit 0
else
    exit 1
fi
